/* include/mont_macros.svh */
`ifndef MONT_MACROS_SVH
`define MONT_MACROS_SVH

// Operand and modulus width, must be even
`define MONT_WIDTH 1024

// Accumulator width with headroom for carries and the sign
`define MONT_ACC_WIDTH (`MONT_WIDTH + 4)

// Adder limbs, one per cycle; must divide the accumulator width
`define MONT_LIMB_COUNT 4

`define MONT_LIMB_WIDTH (`MONT_ACC_WIDTH / `MONT_LIMB_COUNT)

// Radix-4 digits of A
`define MONT_ITERATIONS (`MONT_WIDTH / 2)

`endif

/* logic/mont_pkg.sv */
package mont_pkg;

    // Controller states, each add has an issue and a wait state
    typedef enum logic [4:0] {
        IDLE,
        PRE_2B,
        PRE_2B_WAIT,
        PRE_B,
        PRE_B_WAIT,
        PRE_2M,
        PRE_2M_WAIT,
        PRE_M,
        PRE_M_WAIT,
        DIGIT_ADD,
        DIGIT_ADD_WAIT,
        Q_ADD,
        Q_ADD_WAIT,
        FINAL_SUB,
        FINAL_SUB_WAIT,
        DONE
    } mont_state_t;

    typedef enum logic {
        ADD_OP_ADD,
        ADD_OP_SUB
    } add_op_t;

    // Second adder operand
    typedef enum logic [2:0] {
        TERM_ZERO,
        TERM_B,
        TERM_2B,
        TERM_M,
        TERM_2M,
        TERM_DIGIT_B,
        TERM_Q_M
    } term_sel_t;

    typedef enum logic [2:0] {
        ACC_HOLD,
        ACC_CLEAR,
        ACC_LOAD,
        ACC_LOAD_SHIFT,
        ACC_LOAD_IF_NONNEG
    } acc_op_t;

endpackage

/* logic/mp_adder.sv */
`include "mont_macros.svh"

module mp_adder
    import mont_pkg::*;
(
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       start,
    input  add_op_t                    op,
    input  logic [`MONT_ACC_WIDTH-1:0] in_a,
    input  logic [`MONT_ACC_WIDTH-1:0] in_b,
    output logic [`MONT_ACC_WIDTH:0]   sum,
    output logic                       done
);

    localparam int unsigned ACC_W = `MONT_ACC_WIDTH;
    localparam int unsigned LIMB_W = `MONT_LIMB_WIDTH;
    localparam int unsigned CNT_W = $clog2(`MONT_LIMB_COUNT + 1);
    localparam logic [CNT_W-1:0] LAST_LIMB = CNT_W'(`MONT_LIMB_COUNT - 1);

    logic [ACC_W-1:0]  a_q;
    logic [ACC_W-1:0]  b_q;
    logic [ACC_W-1:0]  res_q;
    logic              sub_q;
    logic              carry_q;
    logic              top_q;
    logic              busy_q;
    logic [CNT_W-1:0]  cnt_q;

    logic [ACC_W-1:0]  a_src;
    logic [ACC_W-1:0]  b_src;
    logic [LIMB_W-1:0] b_limb;
    logic [LIMB_W:0]   limb_sum;
    logic [CNT_W-1:0]  cnt_cur;
    logic              sub_cur;
    logic              cin;
    logic              step;
    logic              last;

    // Limb 0 is handled in the start cycle straight from the inputs
    assign a_src   = start ? in_a : a_q;
    assign b_src   = start ? in_b : b_q;
    assign sub_cur = start ? (op == ADD_OP_SUB) : sub_q;
    assign cin     = start ? sub_cur : carry_q;
    assign cnt_cur = start ? '0 : cnt_q;
    assign step    = start || busy_q;
    assign last    = (cnt_cur == LAST_LIMB);

    // Subtraction as a + ~b + 1
    assign b_limb   = sub_cur ? ~b_src[LIMB_W-1:0] : b_src[LIMB_W-1:0];
    assign limb_sum = {1'b0, a_src[LIMB_W-1:0]} + {1'b0, b_limb} + cin;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
            done   <= 1'b0;
        end else begin
            done <= step && last;
            if (step) begin
                busy_q <= !last;
                cnt_q  <= last ? '0 : cnt_cur + 1'b1;
            end
        end
    end

    // Result limbs enter from the top and end up in order
    always_ff @(posedge clk) begin
        if (step) begin
            a_q     <= a_src >> LIMB_W;
            b_q     <= b_src >> LIMB_W;
            sub_q   <= sub_cur;
            carry_q <= limb_sum[LIMB_W];
            res_q   <= {limb_sum[LIMB_W-1:0], res_q[ACC_W-1:LIMB_W]};
            // Top bit is the carry for add and the borrow for subtract
            if (last) begin
                top_q <= limb_sum[LIMB_W] ^ sub_cur;
            end
        end
    end

    assign sum = {top_q, res_q};

endmodule

/* logic/mont_operand_regs.sv */
`include "mont_macros.svh"

module mont_operand_regs
    import mont_pkg::*;
(
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       load,
    input  logic [`MONT_WIDTH-1:0]     in_a,
    input  logic [`MONT_WIDTH-1:0]     in_b,
    input  logic [`MONT_WIDTH-1:0]     in_m,
    input  logic                       a_shift,
    input  logic                       b3_write,
    input  logic                       m3_write,
    input  logic [`MONT_ACC_WIDTH:0]   sum,
    input  logic [1:0]                 c_low,
    input  term_sel_t                  term_sel,
    output logic [`MONT_ACC_WIDTH-1:0] term
);

    localparam int unsigned W = `MONT_WIDTH;
    localparam int unsigned ACC_W = `MONT_ACC_WIDTH;

    logic [W-1:0]     a_q;
    logic [W-1:0]     b_q;
    logic [W-1:0]     m_q;
    logic [ACC_W-1:0] b3_q;
    logic [ACC_W-1:0] m3_q;

    logic [ACC_W-1:0] b_ext;
    logic [ACC_W-1:0] m_ext;
    logic [ACC_W-1:0] b2;
    logic [ACC_W-1:0] m2;
    logic [ACC_W-1:0] digit_b;
    logic [ACC_W-1:0] q_m;
    logic [1:0]       q_digit;

    // A shifts out one radix-4 digit per iteration
    always_ff @(posedge clk) begin
        if (!resetn) begin
            a_q <= '0;
            b_q <= '0;
            m_q <= '0;
        end else if (load) begin
            a_q <= in_a;
            b_q <= in_b;
            m_q <= in_m;
        end else if (a_shift) begin
            a_q <= {2'b00, a_q[W-1:2]};
        end
    end

    always_ff @(posedge clk) begin
        if (b3_write) begin
            b3_q <= sum[ACC_W-1:0];
        end
        if (m3_write) begin
            m3_q <= sum[ACC_W-1:0];
        end
    end

    assign b_ext = {{(ACC_W - W){1'b0}}, b_q};
    assign m_ext = {{(ACC_W - W){1'b0}}, m_q};
    assign b2    = b_ext << 1;
    assign m2    = m_ext << 1;

    always_comb begin
        case (a_q[1:0])
            2'd0:    digit_b = '0;
            2'd1:    digit_b = b_ext;
            2'd2:    digit_b = b2;
            default: digit_b = b3_q;
        endcase
    end

    // q = -C * M^-1 mod 4, and M^-1 = M mod 4 for odd M
    // M = 3 mod 4 gives q = C, M = 1 mod 4 gives q = -C
    assign q_digit = m_q[1] ? c_low : 2'b00 - c_low;

    always_comb begin
        case (q_digit)
            2'd0:    q_m = '0;
            2'd1:    q_m = m_ext;
            2'd2:    q_m = m2;
            default: q_m = m3_q;
        endcase
    end

    always_comb begin
        case (term_sel)
            TERM_B:       term = b_ext;
            TERM_2B:      term = b2;
            TERM_M:       term = m_ext;
            TERM_2M:      term = m2;
            TERM_DIGIT_B: term = digit_b;
            TERM_Q_M:     term = q_m;
            default:      term = '0;
        endcase
    end

endmodule

/* logic/mont_accumulator.sv */
`include "mont_macros.svh"

module mont_accumulator
    import mont_pkg::*;
(
    input  logic                       clk,
    input  logic                       resetn,
    input  acc_op_t                    acc_op,
    input  logic [`MONT_ACC_WIDTH:0]   sum,
    output logic [`MONT_ACC_WIDTH-1:0] acc,
    output logic [1:0]                 c_low,
    output logic [`MONT_WIDTH-1:0]     result
);

    localparam int unsigned ACC_W = `MONT_ACC_WIDTH;

    logic [ACC_W-1:0] c_q;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            c_q <= '0;
        end else begin
            case (acc_op)
                ACC_CLEAR: c_q <= '0;
                ACC_LOAD:  c_q <= sum[ACC_W-1:0];
                // Divide by 4, the low bits are zero after the q*M add
                ACC_LOAD_SHIFT: c_q <= {1'b0, sum[ACC_W:2]};
                // Keep C - M only when it did not borrow
                ACC_LOAD_IF_NONNEG: begin
                    if (!sum[ACC_W]) begin
                        c_q <= sum[ACC_W-1:0];
                    end
                end
                default: c_q <= c_q;
            endcase
        end
    end

    assign acc    = c_q;
    assign c_low  = c_q[1:0];
    assign result = c_q[`MONT_WIDTH-1:0];

endmodule

/* logic/mont_controller.sv */
`include "mont_macros.svh"

module mont_controller
    import mont_pkg::*;
(
    input  logic      clk,
    input  logic      resetn,
    input  logic      start,
    input  logic      add_done,
    output logic      load,
    output logic      add_start,
    output logic      a_shift,
    output logic      b3_write,
    output logic      m3_write,
    output add_op_t   add_op,
    output term_sel_t term_sel,
    output acc_op_t   acc_op,
    output logic      done
);

    localparam int unsigned CNT_W = $clog2(`MONT_ITERATIONS + 1);
    localparam logic [CNT_W-1:0] LAST_ITER = CNT_W'(`MONT_ITERATIONS - 1);

    mont_state_t      state_q;
    mont_state_t      state_d;
    logic [CNT_W-1:0] iter_q;
    logic             last_iter;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Iteration counter, advanced on every quotient commit
    always_ff @(posedge clk) begin
        if (!resetn) begin
            iter_q <= '0;
        end else if (load) begin
            iter_q <= '0;
        end else if (a_shift) begin
            iter_q <= iter_q + 1'b1;
        end
    end

    assign last_iter = (iter_q == LAST_ITER);

    // Adder operand held through issue and wait
    always_comb begin
        term_sel = TERM_ZERO;
        add_op   = ADD_OP_ADD;
        case (state_q)
            PRE_2B, PRE_2B_WAIT:       term_sel = TERM_2B;
            PRE_B, PRE_B_WAIT:         term_sel = TERM_B;
            PRE_2M, PRE_2M_WAIT:       term_sel = TERM_2M;
            PRE_M, PRE_M_WAIT:         term_sel = TERM_M;
            DIGIT_ADD, DIGIT_ADD_WAIT: term_sel = TERM_DIGIT_B;
            Q_ADD, Q_ADD_WAIT:         term_sel = TERM_Q_M;
            FINAL_SUB, FINAL_SUB_WAIT: begin
                term_sel = TERM_M;
                add_op   = ADD_OP_SUB;
            end
            default: term_sel = TERM_ZERO;
        endcase
    end

    always_comb begin
        state_d   = state_q;
        load      = 1'b0;
        add_start = 1'b0;
        a_shift   = 1'b0;
        b3_write  = 1'b0;
        m3_write  = 1'b0;
        acc_op    = ACC_HOLD;
        case (state_q)
            IDLE: begin
                if (start) begin
                    load    = 1'b1;
                    acc_op  = ACC_CLEAR;
                    state_d = PRE_2B;
                end
            end
            PRE_2B, PRE_B, PRE_2M, PRE_M, DIGIT_ADD, Q_ADD, FINAL_SUB: begin
                add_start = 1'b1;
                state_d   = mont_state_t'(state_q + 1'b1);
            end
            PRE_2B_WAIT: begin
                if (add_done) begin
                    acc_op  = ACC_LOAD;
                    state_d = PRE_B;
                end
            end
            // 3B captured while C goes back to zero for the 3M build
            PRE_B_WAIT: begin
                if (add_done) begin
                    b3_write = 1'b1;
                    acc_op   = ACC_CLEAR;
                    state_d  = PRE_2M;
                end
            end
            PRE_2M_WAIT: begin
                if (add_done) begin
                    acc_op  = ACC_LOAD;
                    state_d = PRE_M;
                end
            end
            PRE_M_WAIT: begin
                if (add_done) begin
                    m3_write = 1'b1;
                    acc_op   = ACC_CLEAR;
                    state_d  = DIGIT_ADD;
                end
            end
            DIGIT_ADD_WAIT: begin
                if (add_done) begin
                    acc_op  = ACC_LOAD;
                    state_d = Q_ADD;
                end
            end
            Q_ADD_WAIT: begin
                if (add_done) begin
                    acc_op  = ACC_LOAD_SHIFT;
                    a_shift = 1'b1;
                    state_d = last_iter ? FINAL_SUB : DIGIT_ADD;
                end
            end
            FINAL_SUB_WAIT: begin
                if (add_done) begin
                    acc_op  = ACC_LOAD_IF_NONNEG;
                    state_d = DONE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    assign done = (state_q == DONE);

endmodule

/* logic/montgomery.sv */
`include "mont_macros.svh"

module montgomery
    import mont_pkg::*;
(
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   start,
    input  logic [`MONT_WIDTH-1:0] in_a,
    input  logic [`MONT_WIDTH-1:0] in_b,
    input  logic [`MONT_WIDTH-1:0] in_m,
    output logic [`MONT_WIDTH-1:0] result,
    output logic                   done
);

    logic                       load;
    logic                       add_start;
    logic                       add_done;
    logic                       a_shift;
    logic                       b3_write;
    logic                       m3_write;
    add_op_t                    add_op;
    term_sel_t                  term_sel;
    acc_op_t                    acc_op;
    logic [`MONT_ACC_WIDTH-1:0] acc;
    logic [`MONT_ACC_WIDTH-1:0] term;
    logic [`MONT_ACC_WIDTH:0]   sum;
    logic [1:0]                 c_low;

    // C is always operand a, the selected term operand b
    mp_adder u_adder (
        .clk    (clk),
        .resetn (resetn),
        .start  (add_start),
        .op     (add_op),
        .in_a   (acc),
        .in_b   (term),
        .sum    (sum),
        .done   (add_done)
    );

    mont_operand_regs u_operands (
        .clk      (clk),
        .resetn   (resetn),
        .load     (load),
        .in_a     (in_a),
        .in_b     (in_b),
        .in_m     (in_m),
        .a_shift  (a_shift),
        .b3_write (b3_write),
        .m3_write (m3_write),
        .sum      (sum),
        .c_low    (c_low),
        .term_sel (term_sel),
        .term     (term)
    );

    mont_accumulator u_acc (
        .clk    (clk),
        .resetn (resetn),
        .acc_op (acc_op),
        .sum    (sum),
        .acc    (acc),
        .c_low  (c_low),
        .result (result)
    );

    mont_controller u_ctrl (
        .clk       (clk),
        .resetn    (resetn),
        .start     (start),
        .add_done  (add_done),
        .load      (load),
        .add_start (add_start),
        .a_shift   (a_shift),
        .b3_write  (b3_write),
        .m3_write  (m3_write),
        .add_op    (add_op),
        .term_sel  (term_sel),
        .acc_op    (acc_op),
        .done      (done)
    );

endmodule

/* verification/tb_montgomery.sv */
`include "mont_macros.svh"

module tb_montgomery
    import mont_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned W = `MONT_WIDTH;
    // Generous bound on one multiplication, in clock cycles
    localparam int unsigned DONE_TIMEOUT =
        4 * (2 * `MONT_ITERATIONS + 8) * (`MONT_LIMB_COUNT + 2);

    logic         clk;
    logic         resetn;
    logic         start;
    logic [W-1:0] in_a;
    logic [W-1:0] in_b;
    logic [W-1:0] in_m;
    logic [W-1:0] result;
    logic         done;

    logic [31:0]  rng_state;
    logic [W-1:0] a;
    logic [W-1:0] b;
    logic [W-1:0] m;
    logic [W-1:0] r;

    montgomery u_dut (
        .clk    (clk),
        .resetn (resetn),
        .start  (start),
        .in_a   (in_a),
        .in_b   (in_b),
        .in_m   (in_m),
        .result (result),
        .done   (done)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic draw_wide(output logic [W-1:0] v);
        v = '0;
        for (int i = 0; i < (W + 31) / 32; i++) begin
            rng_state = xorshift32(rng_state);
            v = (v << 32) | W'(rng_state);
        end
    endtask

    // Odd modulus with top bit set, operands reduced below it
    task automatic draw_operands(output logic [W-1:0] ra, rb, rm);
        logic [W-1:0] raw;
        draw_wide(rm);
        rm[W-1] = 1'b1;
        rm[0] = 1'b1;
        draw_wide(raw);
        ra = raw % rm;
        draw_wide(raw);
        rb = raw % rm;
    endtask

    task automatic compare_result(input logic [W-1:0] got, input logic [W-1:0] expected,
                                  input string what);
        if (got !== expected) begin
            $display("FAIL at %0t ns: %s, got %0h, expected %0h", $time, what, got, expected);
            $display("Errors found");
            $fatal(1, "Result mismatch");
        end
    endtask

    task automatic compare_bit(input logic got, input logic expected, input string what);
        if (got !== expected) begin
            $display("FAIL at %0t ns: %s, got %b, expected %b", $time, what, got, expected);
            $display("Errors found");
            $fatal(1, "Signal mismatch");
        end
    endtask

    // R * 2^W must match A * B modulo M
    task automatic check_rule(input logic [W-1:0] ca, cb, cm, cr);
        logic [2*W-1:0] m_wide;
        logic [2*W-1:0] lhs;
        logic [2*W-1:0] rhs;
        m_wide = {{W{1'b0}}, cm};
        lhs = ({{W{1'b0}}, cr} << W) % m_wide;
        rhs = ({{W{1'b0}}, ca} * {{W{1'b0}}, cb}) % m_wide;
        compare_result(lhs[W-1:0], rhs[W-1:0], "R*2^W mod M against A*B mod M");
        compare_bit(cr < cm, 1'b1, "result below modulus");
    endtask

    task automatic issue_start(input logic [W-1:0] sa, sb, sm);
        start <= 1'b1;
        in_a  <= sa;
        in_b  <= sb;
        in_m  <= sm;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic wait_for_done(output logic [W-1:0] got);
        int  cycles;
        logic seen;
        cycles = 0;
        seen = 1'b0;
        while (!seen && cycles < DONE_TIMEOUT) begin
            @(posedge clk);
            cycles++;
            seen = done;
        end
        if (!seen) begin
            $display("Timed out after %0d cycles waiting for done", cycles);
            $display("Errors found");
            $fatal(1, "Timeout");
        end else begin
            got = result;
        end
    endtask

    task automatic run_and_check(input logic [W-1:0] ra, rb, rm);
        logic [W-1:0] got;
        issue_start(ra, rb, rm);
        wait_for_done(got);
        check_rule(ra, rb, rm, got);
    endtask

    // Done drops after one cycle and result holds while idle
    task automatic check_pulse_and_hold(input logic [W-1:0] held);
        @(posedge clk);
        compare_bit(done, 1'b0, "done lasts one cycle");
        repeat (10) begin
            @(posedge clk);
            compare_bit(done, 1'b0, "done stays low while idle");
            compare_result(result, held, "result stable after done");
        end
    endtask

    initial begin
        clk       = 1'b0;
        resetn    = 1'b0;
        start     = 1'b0;
        in_a      = '0;
        in_b      = '0;
        in_m      = '0;
        rng_state = 32'd81;
        repeat (5) @(posedge clk);
        resetn <= 1'b1;

        // Quiet after reset
        repeat (20) begin
            @(posedge clk);
            compare_bit(done, 1'b0, "done low after reset");
            compare_result(result, '0, "result zero after reset");
        end

        for (int i = 0; i < 8; i++) begin
            draw_operands(a, b, m);
            run_and_check(a, b, m);
        end

        // Edge operands
        draw_operands(a, b, m);
        issue_start('0, b, m);
        wait_for_done(r);
        compare_result(r, '0, "A = 0 gives zero");
        issue_start({{(W-1){1'b0}}, 1'b1}, W'(({{W{1'b0}}, {W{1'b1}}} + 1'b1) % m), m);
        wait_for_done(r);
        compare_result(r, {{(W-1){1'b0}}, 1'b1}, "A = 1, B = 2^W mod M gives one");
        issue_start(m - 1'b1, m - 1'b1, m);
        wait_for_done(r);
        check_rule(m - 1'b1, m - 1'b1, m, r);
        check_pulse_and_hold(r);

        // Starts during a running multiplication are ignored
        draw_operands(a, b, m);
        issue_start(a, b, m);
        repeat (30) begin
            @(posedge clk);
            compare_bit(done, 1'b0, "no early done");
        end
        issue_start(~a, ~b, ~m);
        repeat (100) @(posedge clk);
        issue_start(b, a, m ^ 2'b10);
        wait_for_done(r);
        check_rule(a, b, m, r);

        // Back-to-back start right after done
        draw_operands(a, b, m);
        issue_start(a, b, m);
        wait_for_done(r);
        check_rule(a, b, m, r);
        draw_operands(a, b, m);
        run_and_check(a, b, m);

        $display("No errors");
        $finish;
    end

endmodule

/* montgomery.f */
+incdir+include
logic/mont_pkg.sv
logic/mp_adder.sv
logic/mont_operand_regs.sv
logic/mont_accumulator.sv
logic/mont_controller.sv
logic/montgomery.sv
verification/tb_montgomery.sv

/* Bender.yml */
package:
  name: montgomery

export_include_dirs:
  - include

sources:
  - logic/mont_pkg.sv
  - logic/mp_adder.sv
  - logic/mont_operand_regs.sv
  - logic/mont_accumulator.sv
  - logic/mont_controller.sv
  - logic/montgomery.sv
  - target: test
    files:
      - verification/tb_montgomery.sv
